//--- Bender.yml
package:
  name: spi_ram

sources:
  # design, package first
  - files:
      - hdl/spi_ram_pkg.sv
      - hdl/ram_port_if.sv
      - hdl/spi_frame_receiver.sv
      - hdl/word_ram.sv
      - hdl/spi_reply_transmitter.sv
      - hdl/spi_ram_top.sv

  # testbench and bound properties
  - target: simulation
    files:
      - testbench/spi_ram_props.sv
      - testbench/spi_ram_tb.sv

//--- build.f
hdl/spi_ram_pkg.sv
hdl/ram_port_if.sv
hdl/spi_frame_receiver.sv
hdl/word_ram.sv
hdl/spi_reply_transmitter.sv
hdl/spi_ram_top.sv
testbench/spi_ram_props.sv
testbench/spi_ram_tb.sv

//--- hdl/ram_port_if.sv
`timescale 1ns/100ps

////////////////////////////////////////
// memory request port
// write and read strobes from the spi receiver
////////////////////////////////////////

interface ram_port_if #(
	parameter int address_width = 11
) ();
	import spi_ram_pkg::*;

	// single cycle write strobe with its address and word
	logic write_enable;
	logic [address_width-1:0] write_address;
	word_t write_data;

	// single cycle read strobe
	// data comes back one cycle later
	logic read_enable;
	logic [address_width-1:0] read_address;

	modport receiver (
		output write_enable,
		output write_address,
		output write_data,
		output read_enable,
		output read_address
	);

	modport memory (
		input write_enable,
		input write_address,
		input write_data,
		input read_enable,
		input read_address
	);

endinterface

//--- hdl/spi_frame_receiver.sv
`timescale 1ns/100ps

////////////////////////////////////////
// spi frame receiver
// samples the spi pins on clock100, collects
// 56 bit frames and issues memory requests
////////////////////////////////////////

module spi_frame_receiver #(
	parameter int address_width = 11
) (
	input logic clock100,
	input logic reset,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_select,
	ram_port_if.receiver ram,
	output logic reply_load,
	output logic sclk_fall,
	output logic frame_start,
	output logic [2:0] leds
);
	import spi_ram_pkg::*;

	// wide enough to hold 0 to frame_bits
	localparam int count_width = $clog2(frame_bits + 1);

	// two stage synchronizers
	// index 1 is the safe copy
	logic [1:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] select_sync;
	logic sclk_prev;
	logic select_prev;

	logic selected;
	logic sclk_rise;
	logic take_bit;

	logic [count_width-1:0] bit_count;
	// high the cycle after a bit was shifted in
	logic bit_strobe;
	logic [frame_bits-1:0] shift_reg;

	// decode views of the shift register
	command_t early_command;
	address16_t early_address;
	command_t frame_command;
	address16_t frame_address;

	logic read_request;
	logic write_request;

	// select idles high, sclk idles low in mode 0
	always_ff @(posedge clock100) begin
		if (reset) begin
			sclk_sync <= 2'b00;
			select_sync <= 2'b11;
			sclk_prev <= 1'b0;
			select_prev <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[0], spi_sclk};
			select_sync <= {select_sync[0], spi_select};
			sclk_prev <= sclk_sync[1];
			select_prev <= select_sync[1];
		end
	end

	// data pin only needs the delay to line up with sclk
	always_ff @(posedge clock100) begin
		mosi_sync <= {mosi_sync[0], spi_mosi};
	end

	// edge events in the clock100 domain
	assign selected = ~select_sync[1];
	assign sclk_rise = sclk_sync[1] & ~sclk_prev;
	assign sclk_fall = sclk_prev & ~sclk_sync[1] & selected;
	assign frame_start = select_prev & ~select_sync[1];

	// bits past the end of a frame are dropped
	assign take_bit = selected & sclk_rise & (bit_count < count_width'(frame_bits));

	// deselect clears the count
	// this also kills aborted frames
	always_ff @(posedge clock100) begin
		if (reset) begin
			bit_count <= '0;
			bit_strobe <= 1'b0;
		end else begin
			bit_strobe <= take_bit;
			if (!selected) begin
				bit_count <= '0;
			end else if (take_bit) begin
				bit_count <= bit_count + 1'b1;
			end
		end
	end

	// msb first, newest bit enters at the bottom
	always_ff @(posedge clock100) begin
		if (take_bit) begin
			shift_reg <= {shift_reg[frame_bits-2:0], mosi_sync[1]};
		end
	end

	// after 24 bits command and address sit at the bottom
	assign early_command = command_t'(shift_reg[header_bits-1 -: command_bits]);
	assign early_address = shift_reg[address_bits-1:0];

	// full frame, fields in their final place
	assign frame_command = command_t'(shift_reg[frame_bits-1 -: command_bits]);
	assign frame_address = shift_reg[data_bits +: address_bits];

	// read goes out as soon as the address is in
	assign read_request = bit_strobe && (bit_count == count_width'(header_bits))
		&& (early_command == command_read);

	// write only once all 56 bits arrived
	assign write_request = bit_strobe && (bit_count == count_width'(frame_bits))
		&& (frame_command == command_write);

	// upper address bits alias
	assign ram.read_enable = read_request;
	assign ram.read_address = early_address[address_width-1:0];
	assign ram.write_enable = write_request;
	assign ram.write_address = frame_address[address_width-1:0];
	assign ram.write_data = shift_reg[data_bits-1:0];

	// memory answers one cycle after the read strobe
	always_ff @(posedge clock100) begin
		if (reset) begin
			reply_load <= 1'b0;
		end else begin
			reply_load <= read_request;
		end
	end

	// leds mirror the last completed write
	always_ff @(posedge clock100) begin
		if (reset) begin
			leds <= 3'b000;
		end else if (write_request) begin
			leds <= shift_reg[2:0];
		end
	end

endmodule

//--- hdl/spi_ram_pkg.sv
////////////////////////////////////////
// spi to block memory bridge definitions
// frame layout, command codes and the data word
////////////////////////////////////////

package spi_ram_pkg;

	// field widths of one spi frame, msb first
	localparam int command_bits = 8;
	localparam int address_bits = 16;
	localparam int data_bits = 32;
	localparam int frame_bits = command_bits + address_bits + data_bits;

	// bits before the data field starts
	localparam int header_bits = command_bits + address_bits;

	// one memory word, also the frame data field
	typedef logic [data_bits-1:0] word_t;

	// full address field as sent by the master
	// only the low bits reach the memory
	typedef logic [address_bits-1:0] address16_t;

	// command byte
	// any other value is legal and does nothing
	typedef enum logic [command_bits-1:0] {
		command_write = 8'h01,
		command_read = 8'h02
	} command_t;

endpackage

//--- hdl/spi_ram_top.sv
`timescale 1ns/100ps

////////////////////////////////////////
// spi to block memory bridge
// command, address and data frames from
// an spi master into a 32 bit wide ram
////////////////////////////////////////

module spi_ram_top #(
	parameter int address_width = 11
) (
	input logic clock100,
	input logic reset,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_select,
	output logic spi_miso,
	output logic [2:0] leds
);
	import spi_ram_pkg::*;

	// memory requests from receiver to ram
	ram_port_if #(
		.address_width(address_width)
	) ram_port ();

	// ram output to the transmitter
	word_t read_data;

	// event pulses from receiver to transmitter
	logic reply_load;
	logic sclk_fall;
	logic frame_start;

	spi_frame_receiver #(
		.address_width(address_width)
	) spi_frame_receiver_inst (
		.clock100(clock100),
		.reset(reset),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_select(spi_select),
		.ram(ram_port.receiver),
		.reply_load(reply_load),
		.sclk_fall(sclk_fall),
		.frame_start(frame_start),
		.leds(leds)
	);

	word_ram #(
		.address_width(address_width)
	) word_ram_inst (
		.clock100(clock100),
		.ram(ram_port.memory),
		.read_data(read_data)
	);

	// miso driver
	spi_reply_transmitter spi_reply_transmitter_inst (
		.clock100(clock100),
		.reset(reset),
		.read_data(read_data),
		.reply_load(reply_load),
		.sclk_fall(sclk_fall),
		.frame_start(frame_start),
		.spi_miso(spi_miso)
	);

endmodule

//--- hdl/spi_reply_transmitter.sv
`timescale 1ns/100ps

////////////////////////////////////////
// spi reply transmitter
// shifts the read word out on miso,
// one bit per falling sclk edge
////////////////////////////////////////

module spi_reply_transmitter (
	input logic clock100,
	input logic reset,
	input spi_ram_pkg::word_t read_data,
	input logic reply_load,
	input logic sclk_fall,
	input logic frame_start,
	output logic spi_miso
);
	import spi_ram_pkg::*;

	word_t shift_out;
	// miso only shows data once a reply was loaded
	logic loaded;
	// bit 31 must survive the fall right after bit 24
	logic hold_first;
	logic advance;

	// the first fall after loading keeps bit 31 on the line
	assign advance = sclk_fall & loaded & ~hold_first;

	// new frame drops any old reply
	always_ff @(posedge clock100) begin
		if (reset) begin
			loaded <= 1'b0;
			hold_first <= 1'b0;
		end else if (frame_start) begin
			loaded <= 1'b0;
			hold_first <= 1'b0;
		end else if (reply_load) begin
			loaded <= 1'b1;
			hold_first <= 1'b1;
		end else if (sclk_fall && loaded) begin
			hold_first <= 1'b0;
		end
	end

	// msb first, zeros fill from the bottom
	always_ff @(posedge clock100) begin
		if (reply_load) begin
			shift_out <= read_data;
		end else if (advance) begin
			shift_out <= {shift_out[data_bits-2:0], 1'b0};
		end
	end

	assign spi_miso = loaded & shift_out[data_bits-1];

endmodule

//--- hdl/word_ram.sv
`timescale 1ns/100ps

////////////////////////////////////////
// word memory
// simple dual port, one write and one
// registered read port on clock100
////////////////////////////////////////

module word_ram #(
	parameter int address_width = 11
) (
	input logic clock100,
	ram_port_if.memory ram,
	output spi_ram_pkg::word_t read_data
);
	import spi_ram_pkg::*;

	localparam int depth = 2 ** address_width;

	// plain array so synthesis maps it to block ram
	word_t memory [depth];

	// write lands at the edge where the strobe is high
	always_ff @(posedge clock100) begin
		if (ram.write_enable) begin
			memory[ram.write_address] <= ram.write_data;
		end
	end

	// output register holds the word until the next read
	// valid the cycle after read_enable
	always_ff @(posedge clock100) begin
		if (ram.read_enable) begin
			read_data <= memory[ram.read_address];
		end
	end

endmodule

//--- testbench/spi_ram_props.sv
`timescale 1ns/100ps

////////////////////////////////////////
// bridge properties
// request strobes, reply load and idle miso
////////////////////////////////////////

module spi_ram_props (
	input logic clock100,
	input logic reset,
	input logic write_enable,
	input logic read_enable,
	input logic reply_load,
	input logic spi_select,
	input logic spi_miso
);

	// one request kind per cycle
	strobes_apart: assert property (@(posedge clock100) disable iff (reset)
		!(write_enable && read_enable))
		else $error("write and read strobes high in the same cycle");

	// single cycle strobes
	write_single: assert property (@(posedge clock100) disable iff (reset)
		write_enable |=> !write_enable)
		else $error("write strobe longer than one cycle");
	read_single: assert property (@(posedge clock100) disable iff (reset)
		read_enable |=> !read_enable)
		else $error("read strobe longer than one cycle");

	// reply loads exactly one cycle after the read
	load_after_read: assert property (@(posedge clock100) disable iff (reset)
		read_enable |=> reply_load)
		else $error("reply load missing after read strobe");
	load_only_after_read: assert property (@(posedge clock100) disable iff (reset)
		reply_load |-> $past(read_enable))
		else $error("reply load without a read strobe");

	// deselected, miso stays low
	miso_idle: assert property (@(posedge clock100) disable iff (reset)
		spi_select |-> !spi_miso)
		else $error("miso high while select is high");

endmodule

bind spi_ram_top spi_ram_props spi_ram_props_inst (
	.clock100(clock100),
	.reset(reset),
	.write_enable(ram_port.write_enable),
	.read_enable(ram_port.read_enable),
	.reply_load(reply_load),
	.spi_select(spi_select),
	.spi_miso(spi_miso)
);

//--- testbench/spi_ram_tb.sv
`timescale 1ns/100ps

////////////////////////////////////////
// testbench for the spi to block memory bridge
// plays spi frames from a table, checks miso and leds
////////////////////////////////////////

module spi_ram_tb;
	import spi_ram_pkg::*;

	localparam int address_width = 11;
	localparam int depth = 2 ** address_width;
	// clock100 cycles per sclk half period
	localparam int half_period = 8;
	// idle cycles with select high between frames
	localparam int frame_gap = 12;
	localparam int write_wait_limit = 64;
	localparam int run_limit = 100000;

	// one frame and what it should produce
	typedef struct {
		string name;
		logic [command_bits-1:0] command;
		address16_t address;
		word_t data;
		int abort_at;
		word_t expect_reply;
		logic [2:0] expect_leds;
	} row_t;

	logic clock100;
	logic reset;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_select;
	logic spi_miso;
	logic [2:0] leds;

	row_t rows[$];
	// reference memory, indexed by the aliased address
	word_t model_mem [int];
	logic [2:0] model_leds;

	int mismatch_errors;
	int timeout_errors;
	int expected_writes;
	int write_strobes = 0;
	word_t reply;

	spi_ram_top #(
		.address_width(address_width)
	) spi_ram_top_inst (
		.clock100(clock100),
		.reset(reset),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_select(spi_select),
		.spi_miso(spi_miso),
		.leds(leds)
	);

	// 100 ns period
	always #50 clock100 = ~clock100;

	// writes seen at the memory port
	always @(posedge clock100) begin
		if (spi_ram_top_inst.ram_port.write_enable === 1'b1) begin
			write_strobes <= write_strobes + 1;
		end
	end

	// upper address bits are dropped
	function automatic int ram_index(input address16_t address);
		return int'(address) % depth;
	endfunction

	task automatic write_row(input string name, input address16_t address,
			input word_t data, input int abort_at);
		row_t row;
		row.name = name;
		row.command = command_write;
		row.address = address;
		row.data = data;
		row.abort_at = abort_at;
		// only a complete frame reaches memory and leds
		if (abort_at == 0) begin
			model_mem[ram_index(address)] = data;
			model_leds = data[2:0];
		end
		// nothing on miso during writes
		row.expect_reply = '0;
		row.expect_leds = model_leds;
		rows.push_back(row);
	endtask

	task automatic read_row(input string name, input address16_t address);
		row_t row;
		row.name = name;
		row.command = command_read;
		row.address = address;
		row.data = '0;
		row.abort_at = 0;
		row.expect_reply = model_mem[ram_index(address)];
		row.expect_leds = model_leds;
		rows.push_back(row);
	endtask

	// unknown command, memory and leds stay as they are
	task automatic ignored_row(input string name, input logic [command_bits-1:0] command,
			input address16_t address, input word_t data);
		row_t row;
		row.name = name;
		row.command = command;
		row.address = address;
		row.data = data;
		row.abort_at = 0;
		row.expect_reply = '0;
		row.expect_leds = model_leds;
		rows.push_back(row);
	endtask

	task automatic build_table();
		// simple write and read back
		write_row("write 0123", 16'h0123, $urandom(), 0);
		read_row("read 0123", 16'h0123);
		// lowest, highest and a middle word
		write_row("write 0000", 16'h0000, $urandom(), 0);
		write_row("write 07ff", 16'h07ff, $urandom(), 0);
		write_row("write 0200", 16'h0200, $urandom(), 0);
		read_row("read 07ff", 16'h07ff);
		read_row("read 0000", 16'h0000);
		read_row("read 0200", 16'h0200);
		read_row("read 0123 again", 16'h0123);
		// 0805 and f805 both land on word 5
		write_row("write 0805", 16'h0805, $urandom(), 0);
		read_row("read 0005 alias", 16'h0005);
		write_row("write f805", 16'hf805, $urandom(), 0);
		read_row("read 0805 alias", 16'h0805);
		// 0405 is a word of its own with 11 bits
		write_row("write 0405", 16'h0405, $urandom(), 0);
		read_row("read 0005 after 0405", 16'h0005);
		read_row("read 0405", 16'h0405);
		// frames that must change nothing
		ignored_row("command 5a", 8'h5a, 16'h0123, $urandom());
		read_row("read 0123 after 5a", 16'h0123);
		write_row("write 0123 cut at 40", 16'h0123, $urandom(), 40);
		write_row("write 0123 cut at 10", 16'h0123, $urandom(), 10);
		read_row("read 0123 after cuts", 16'h0123);
		// leds from the low bits
		write_row("leds 5", 16'h0010, 32'hcafe_0005, 0);
		write_row("leds 2", 16'h0011, 32'h1234_567a, 0);
		ignored_row("command 00", 8'h00, 16'h0011, 32'h0000_0007);
		read_row("read 0010", 16'h0010);
		read_row("read 0011", 16'h0011);
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			mismatch_errors++;
			$display("Mismatch %s: reply expected %08h actual %08h", name, expected, actual);
		end
	endtask

	task automatic check_leds(input string name, input logic [2:0] expected,
			input logic [2:0] actual);
		if (actual !== expected) begin
			mismatch_errors++;
			$display("Mismatch %s: leds expected %03b actual %03b", name, expected, actual);
		end
	endtask

	// miso during command and address bits
	task automatic quiet_bit_check(input string name, input int bit_number, input logic actual);
		if (actual !== 1'b0) begin
			mismatch_errors++;
			$display("Mismatch %s: miso at bit %0d expected 0 actual %b",
				name, bit_number, actual);
		end
	endtask

	// mode 0 master, msb first, optional early deselect
	task automatic send_frame(input string name, input logic [command_bits-1:0] command,
			input address16_t address, input word_t data, input int abort_at,
			output word_t sampled);
		logic [frame_bits-1:0] frame;
		int last_bit;
		logic miso_bit;
		frame = {command, address, data};
		last_bit = (abort_at == 0) ? frame_bits : abort_at;
		sampled = '0;
		@(posedge clock100);
		spi_select <= 1'b0;
		for (int bit_index = 0; bit_index < last_bit; bit_index++) begin
			// mosi changes while sclk is low
			spi_sclk <= 1'b0;
			spi_mosi <= frame[frame_bits-1-bit_index];
			repeat (half_period) @(posedge clock100);
			// sample miso as sclk rises
			miso_bit = spi_miso;
			spi_sclk <= 1'b1;
			if (bit_index < header_bits) begin
				quiet_bit_check(name, bit_index + 1, miso_bit);
			end else begin
				sampled = {sampled[data_bits-2:0], miso_bit};
			end
			repeat (half_period) @(posedge clock100);
		end
		spi_sclk <= 1'b0;
		repeat (half_period) @(posedge clock100);
		spi_select <= 1'b1;
		spi_mosi <= 1'b0;
		repeat (frame_gap) @(posedge clock100);
	endtask

	task automatic wait_write_count(input string name, input int expected);
		int waited;
		waited = 0;
		while (write_strobes != expected && waited < write_wait_limit) begin
			@(posedge clock100);
			waited++;
		end
		if (write_strobes != expected) begin
			timeout_errors++;
			$display("%s: memory saw %0d writes after waiting %0d cycles, expected %0d",
				name, write_strobes, waited, expected);
		end
	endtask

	// watchdog for the whole run
	initial begin
		repeat (run_limit) @(posedge clock100);
		$display("run did not finish within %0d clock cycles", run_limit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		clock100 = 1'b0;
		reset = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_select = 1'b1;
		mismatch_errors = 0;
		timeout_errors = 0;
		expected_writes = 0;
		model_leds = 3'b000;
		void'($urandom(79));
		build_table();
		repeat (16) @(posedge clock100);
		reset <= 1'b0;
		repeat (4) @(posedge clock100);
		check_leds("after reset", 3'b000, leds);
		foreach (rows[i]) begin
			send_frame(rows[i].name, rows[i].command, rows[i].address, rows[i].data,
				rows[i].abort_at, reply);
			if (rows[i].command == command_write && rows[i].abort_at == 0) begin
				expected_writes++;
			end
			wait_write_count(rows[i].name, expected_writes);
			check_word(rows[i].name, rows[i].expect_reply, reply);
			check_leds(rows[i].name, rows[i].expect_leds, leds);
		end
		$display("errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
		if (mismatch_errors + timeout_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
